// ==== source/frog_pkg.sv ====
// ------------------------------------------------------------
// Frogger score subsystem shared definitions
// Widths, fixed values, FSM states and segment bundles
// ------------------------------------------------------------
package frog_pkg;

  // Frog row index, rows 0 to 7
  typedef logic [2:0] rowT;

  // Score value, saturates at 63
  typedef logic [5:0] scoreT;

  // One decimal digit
  typedef logic [3:0] digitT;

  // Debounce stability counter
  typedef logic [4:0] debounceCountT;

  // Segments a to g, a in the MSB
  typedef logic [6:0] segT;

  // Both displays, tens on the first one
  typedef struct packed {
    segT tens;
    segT units;
  } segPairT;

  // Progress FSM
  typedef enum logic {
    PressWait,
    ReleaseWait
  } frogStateT;

  // Stable cycles needed before the debounced level follows the button
  localparam debounceCountT DEBOUNCE_CYCLES = 5'd16;

  // Row at which a hop scores and wraps back to the start
  localparam rowT TOP_ROW = 3'd7;

  // Highest score the 6-bit counter may hold
  localparam scoreT MAX_SCORE = 6'd63;

endpackage

// ==== source/ButtonDebounce.sv ====
// ------------------------------------------------------------
// Push button debouncer
// Output follows the raw level once it has been stable long enough
// ------------------------------------------------------------
module ButtonDebounce
  import frog_pkg::*;
(
  input  logic i_Clk,
  input  logic i_rstN,

  // Raw bouncy button level
  input  logic i_Raw,

  // Filtered level
  output logic o_Deb
);

  debounceCountT count;

  // Count cycles where raw and filtered levels disagree
  always_ff @(posedge i_Clk or negedge i_rstN)
  begin
    if (!i_rstN)
    begin
      count <= '0;
      o_Deb <= 1'b0;
    end
    else if (i_Raw == o_Deb)
    begin
      // Bounce back to the held level restarts the count
      count <= '0;
    end
    else if (count == DEBOUNCE_CYCLES)
    begin
      o_Deb <= i_Raw;
      count <= '0;
    end
    else
    begin
      count <= count + 5'd1;
    end
  end

  // Counter must stop at the threshold
  assert property (@(posedge i_Clk) disable iff (!i_rstN)
    count <= DEBOUNCE_CYCLES)
    else $error("Debounce counter passed its limit");

endmodule

// ==== source/FrogProgress.sv ====
// ------------------------------------------------------------
// Frog progress counter
// Hops the frog one row per press, scores at the top row
// ------------------------------------------------------------
module FrogProgress
  import frog_pkg::*;
(
  input  logic  i_Clk,
  input  logic  i_rstN,

  // Debounced up button
  input  logic  i_Up,

  // Collision level from the game logic
  input  logic  i_Collision,

  // Current row and score
  output rowT   o_Row,
  output scoreT o_Score
);

  frogStateT state;

  always_ff @(posedge i_Clk or negedge i_rstN)
  begin
    if (!i_rstN)
    begin
      state   <= PressWait;
      o_Row   <= '0;
      o_Score <= '0;
    end
    else if (i_Collision)
    begin
      // Collision wins over any hop
      state   <= PressWait;
      o_Row   <= '0;
      o_Score <= '0;
    end
    else
    begin
      unique case (state)
        PressWait:
        begin
          if (i_Up)
          begin
            state <= ReleaseWait;
            if (o_Row == TOP_ROW)
            begin
              // Crossing done, back to the start row
              o_Row <= '0;
              if (o_Score != MAX_SCORE)
              begin
                o_Score <= o_Score + 6'd1;
              end
            end
            else
            begin
              o_Row <= o_Row + 3'd1;
            end
          end
        end

        ReleaseWait:
        begin
          // Wait for release so a held button hops once
          if (!i_Up)
          begin
            state <= PressWait;
          end
        end

        default:
        begin
          state <= PressWait;
        end
      endcase
    end
  end

  // Collision clears the frog on the next cycle
  assert property (@(posedge i_Clk) disable iff (!i_rstN)
    i_Collision |=> (o_Row == '0 && o_Score == '0))
    else $error("Row or score not cleared after collision");

  // Score saturates instead of wrapping
  assert property (@(posedge i_Clk) disable iff (!i_rstN)
    (o_Score == MAX_SCORE && !i_Collision) |=> (o_Score == MAX_SCORE))
    else $error("Score left its maximum without a collision");

endmodule

// ==== source/SevenSegmentsDisplay.sv ====
// ------------------------------------------------------------
// Two-digit seven-segment score display
// Splits the score into tens and units, drives active-low segments
// ------------------------------------------------------------
module SevenSegmentsDisplay
  import frog_pkg::*;
(
  input  logic    i_Clk,
  input  logic    i_rstN,

  // Score from the progress counter
  input  scoreT   i_Score,

  // Active-low segments, tens and units
  output segPairT o_Segments
);

  digitT tensQ;
  digitT unitsQ;

  // Active-high pattern, segment a in the MSB
  function automatic segT encodeDigit(input digitT digit);
    segT seg;
    case (digit)
      4'd0:    seg = 7'h7E;
      4'd1:    seg = 7'h30;
      4'd2:    seg = 7'h6D;
      4'd3:    seg = 7'h79;
      4'd4:    seg = 7'h33;
      4'd5:    seg = 7'h5B;
      4'd6:    seg = 7'h5F;
      4'd7:    seg = 7'h70;
      4'd8:    seg = 7'h7F;
      4'd9:    seg = 7'h7B;
      default: seg = 7'h00;
    endcase
    return seg;
  endfunction

  // Stage one holds the decimal digits
  always_ff @(posedge i_Clk or negedge i_rstN)
  begin
    if (!i_rstN)
    begin
      tensQ  <= '0;
      unitsQ <= '0;
    end
    else
    begin
      tensQ  <= digitT'(i_Score / 6'd10);
      unitsQ <= digitT'(i_Score % 6'd10);
    end
  end

  // Stage two holds the inverted encodings for common anode parts
  always_ff @(posedge i_Clk or negedge i_rstN)
  begin
    if (!i_rstN)
    begin
      o_Segments.tens  <= ~segT'(7'h7E);
      o_Segments.units <= ~segT'(7'h7E);
    end
    else
    begin
      o_Segments.tens  <= ~encodeDigit(tensQ);
      o_Segments.units <= ~encodeDigit(unitsQ);
    end
  end

  // Digits stay decimal, so no blank pattern reaches the displays
  assert property (@(posedge i_Clk) disable iff (!i_rstN)
    (tensQ < 4'd10) && (unitsQ < 4'd10))
    else $error("Registered digit out of decimal range");

endmodule

// ==== source/FroggerScoreTop.sv ====
// ------------------------------------------------------------
// Frogger score subsystem top level
// Debounced up button to row, score and seven-segment output
// ------------------------------------------------------------
module FroggerScoreTop
  import frog_pkg::*;
(
  input  logic    i_Clk,
  input  logic    i_rstN,

  // Raw up button and collision level
  input  logic    i_UpBtn,
  input  logic    i_Collision,

  // Frog row and active-low score segments
  output rowT     o_Row,
  output segPairT o_Segments
);

  logic  w_UpDeb;
  scoreT w_Score;

  ButtonDebounce i_ButtonDebounce (
    .i_Clk  (i_Clk),
    .i_rstN (i_rstN),
    .i_Raw  (i_UpBtn),
    .o_Deb  (w_UpDeb)
  );

  FrogProgress i_FrogProgress (
    .i_Clk       (i_Clk),
    .i_rstN      (i_rstN),
    .i_Up        (w_UpDeb),
    .i_Collision (i_Collision),
    .o_Row       (o_Row),
    .o_Score     (w_Score)
  );

  // Two cycles from score to segments
  SevenSegmentsDisplay i_SevenSegmentsDisplay (
    .i_Clk      (i_Clk),
    .i_rstN     (i_rstN),
    .i_Score    (w_Score),
    .o_Segments (o_Segments)
  );

endmodule

// ==== sim/tb_FroggerScore.sv ====
// ------------------------------------------------------------
// Frogger score subsystem testbench
// Directed tests with button bounce, collisions and saturation
// ------------------------------------------------------------
module tb_FroggerScore
  import frog_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CYCLE_LIMIT    = 30000;
  localparam int ROW_WAIT_LIMIT = 200;
  localparam int SETTLE_CYCLES  = int'(DEBOUNCE_CYCLES) + 2;
  localparam int QUIET_CYCLES   = 3 * int'(DEBOUNCE_CYCLES);

  // Active-high digit patterns, segment a in the MSB
  localparam segT DIGIT_PATTERNS [10] = '{
    7'h7E, 7'h30, 7'h6D, 7'h79, 7'h33, 7'h5B, 7'h5F, 7'h70, 7'h7F, 7'h7B
  };

  logic    i_Clk;
  logic    i_rstN;
  logic    i_UpBtn;
  logic    i_Collision;
  rowT     o_Row;
  segPairT o_Segments;

  // Reference model of the frog
  rowT     expRow;
  scoreT   expScore;

  integer  seed;
  int      errorCount = 0;
  int      cycleCount = 0;

  FroggerScoreTop i_FroggerScoreTop (
    .i_Clk       (i_Clk),
    .i_rstN      (i_rstN),
    .i_UpBtn     (i_UpBtn),
    .i_Collision (i_Collision),
    .o_Row       (o_Row),
    .o_Segments  (o_Segments)
  );

  initial
  begin
    i_Clk = 1'b0;
    forever #2 i_Clk = ~i_Clk;
  end

  // Global bound on the run length
  always @(posedge i_Clk)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= CYCLE_LIMIT)
    begin
      $display("Run stopped at the limit of %0d clock cycles", CYCLE_LIMIT);
      $display("Errors: %0d", errorCount);
      $display(">>> FAIL");
      $finish;
    end
  end

  // One hop of the model, wraps the row and saturates the score at the top
  task automatic advanceModel();
    if (expRow == TOP_ROW)
    begin
      expRow = '0;
      if (expScore != MAX_SCORE)
      begin
        expScore = expScore + 6'd1;
      end
    end
    else
    begin
      expRow = expRow + 3'd1;
    end
  endtask

  task automatic scoreToSegments(input scoreT score, output segPairT seg);
    digitT tens;
    digitT units;
    tens      = digitT'(score / 6'd10);
    units     = digitT'(score % 6'd10);
    seg.tens  = ~DIGIT_PATTERNS[tens];
    seg.units = ~DIGIT_PATTERNS[units];
  endtask

  task automatic checkRow(input string what);
    assert (o_Row == expRow)
    else
    begin
      errorCount++;
      $display("Fail %0t: %s, row %0d, expected %0d", $time, what, o_Row, expRow);
    end
  endtask

  task automatic checkSegments(input scoreT score, input string what);
    segPairT expSeg;
    scoreToSegments(score, expSeg);
    assert (o_Segments == expSeg)
    else
    begin
      errorCount++;
      $display("Fail %0t: %s, segments %h, expected %h for score %0d",
        $time, what, o_Segments, expSeg, score);
    end
  endtask

  task automatic waitRowChange(input rowT prevRow);
    int waited;
    waited = 0;
    while (o_Row == prevRow && waited < ROW_WAIT_LIMIT)
    begin
      @(negedge i_Clk);
      waited++;
    end
    if (o_Row == prevRow)
    begin
      errorCount++;
      $display("Row stayed at %0d for %0d cycles after a press, at %0t",
        prevRow, ROW_WAIT_LIMIT, $time);
    end
  endtask

  task automatic watchRowSteady(input int cycles, input string what);
    repeat (cycles)
    begin
      @(negedge i_Clk);
      checkRow(what);
    end
  endtask

  // Random toggles, each shorter than the debounce window
  task automatic bounceBurst(input logic finalLevel);
    int toggles;
    int hold;
    toggles = 1 + ({$random(seed)} % 8);
    repeat (toggles)
    begin
      @(posedge i_Clk);
      i_UpBtn <= ~i_UpBtn;
      hold = 1 + ({$random(seed)} % (int'(DEBOUNCE_CYCLES) - 1));
      repeat (hold - 1) @(posedge i_Clk);
    end
    @(posedge i_Clk);
    i_UpBtn <= finalLevel;
  endtask

  // Press, check row and segments, optionally hold, then release
  task automatic hop(input bit withBounce, input int holdCycles);
    rowT   prevRow;
    scoreT prevScore;
    @(negedge i_Clk);
    prevRow   = o_Row;
    prevScore = expScore;
    advanceModel();
    if (withBounce)
    begin
      bounceBurst(1'b1);
    end
    else
    begin
      @(posedge i_Clk);
      i_UpBtn <= 1'b1;
    end
    waitRowChange(prevRow);
    checkRow("hop");
    @(negedge i_Clk);
    if (expScore != prevScore)
    begin
      checkSegments(prevScore, "one cycle after score change");
    end
    @(negedge i_Clk);
    checkSegments(expScore, "two cycles after hop");
    watchRowSteady(holdCycles, "held button");
    @(posedge i_Clk);
    i_UpBtn <= 1'b0;
    repeat (SETTLE_CYCLES) @(posedge i_Clk);
  endtask

  task automatic resetTest();
    @(negedge i_Clk);
    checkRow("after reset");
    checkSegments(6'd0, "after reset");
  endtask

  task automatic glitchTest();
    int width;
    width = 1;
    while (width < int'(DEBOUNCE_CYCLES))
    begin
      @(posedge i_Clk);
      i_UpBtn <= 1'b1;
      repeat (width) @(posedge i_Clk);
      i_UpBtn <= 1'b0;
      watchRowSteady(QUIET_CYCLES, "short pulse");
      width = width + 7;
    end
    repeat (2)
    begin
      bounceBurst(1'b0);
      watchRowSteady(QUIET_CYCLES, "bounce back to 0");
    end
  endtask

  task automatic hoppingTest();
    hop(1'b0, 0);
    hop(1'b1, 0);
    // Long hold must give a single hop
    hop(1'b0, QUIET_CYCLES);
    hop(1'b1, 0);
    hop(1'b1, 0);
  endtask

  task automatic scoringTest();
    int hopCount;
    hopCount = 0;
    while (expScore < 6'd12)
    begin
      hop(hopCount % 8 == 0, 0);
      hopCount++;
    end
  endtask

  task automatic collisionTest();
    hop(1'b0, 0);
    hop(1'b0, 0);
    @(posedge i_Clk);
    i_Collision <= 1'b1;
    expRow   = '0;
    expScore = '0;
    @(posedge i_Clk);
    @(negedge i_Clk);
    checkRow("collision");
    // Frog stays put while the collision holds
    @(posedge i_Clk);
    i_UpBtn <= 1'b1;
    watchRowSteady(QUIET_CYCLES, "press during collision");
    checkSegments(expScore, "collision");
    @(posedge i_Clk);
    i_UpBtn <= 1'b0;
    repeat (SETTLE_CYCLES) @(posedge i_Clk);
    i_Collision <= 1'b0;
    hop(1'b0, 0);
  endtask

  task automatic saturationTest();
    @(posedge i_Clk);
    i_Collision <= 1'b1;
    @(posedge i_Clk);
    i_Collision <= 1'b0;
    expRow   = '0;
    expScore = '0;
    repeat (64 * 8)
    begin
      hop(1'b0, 0);
    end
    @(negedge i_Clk);
    checkSegments(MAX_SCORE, "after 64 crossings");
    repeat (8)
    begin
      hop(1'b0, 0);
    end
    @(negedge i_Clk);
    checkSegments(MAX_SCORE, "crossing at full score");
    checkRow("crossing at full score");
  endtask

  initial
  begin
    seed        = 32'h397;
    i_rstN      = 1'b0;
    i_UpBtn     = 1'b0;
    i_Collision = 1'b0;
    expRow      = '0;
    expScore    = '0;
    repeat (8) @(posedge i_Clk);
    i_rstN <= 1'b1;
    resetTest();
    glitchTest();
    hoppingTest();
    scoringTest();
    collisionTest();
    saturationTest();
    $display("Errors: %0d", errorCount);
    if (errorCount == 0)
    begin
      $display(">>> PASS");
    end
    else
    begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
source/frog_pkg.sv
source/ButtonDebounce.sv
source/FrogProgress.sv
source/SevenSegmentsDisplay.sv
source/FroggerScoreTop.sv
sim/tb_FroggerScore.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the Frogger score testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f flist.f \
  --top-module tb_FroggerScore -Mdir obj_dir -o tb_FroggerScore

./obj_dir/tb_FroggerScore > sim.log 2>&1 || true
cat sim.log

if grep -qxF '>>> PASS' sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
